/* hdl/maze_pkg.sv */
//====================
// maze geometry and screen tiling constants
// cell and pixel coordinate types
// robot position update message
//====================

`default_nettype none

package maze_pkg;

	// maze size in cells
	localparam int CELL_COLS = 4;
	localparam int CELL_ROWS = 5;

	// screen tiling
	localparam int TILES_PER_CELL = 9;
	localparam int TILE_PIXELS    = 10;
	localparam int MAP_TILE_COLS  = 37;
	localparam int MAP_TILE_ROWS  = 46;
	localparam int MAP_PIXEL_W    = 370;
	localparam int MAP_PIXEL_H    = 460;

	// done field value sent with the last update of a run
	localparam int DONE_CODE = 7;

	typedef logic [1:0] cell_x_t;
	typedef logic [2:0] cell_y_t;
	typedef logic [9:0] pixel_coord_t;

	// 0 none, 1 7 kHz, 2 12 kHz, 3 17 kHz
	typedef logic [1:0] treasure_t;

	// 16-bit update, msb first
	typedef struct packed {
		logic [2:0] done;
		cell_y_t    y;
		cell_x_t    x;
		treasure_t  treasure;
		logic       visited;
		logic       unreachable;
		logic       wall_west;
		logic       wall_east;
		logic       wall_south;
		logic       wall_north;
	} maze_update_t;

endpackage

`default_nettype wire

/* hdl/color_pkg.sv */
//====================
// cell state codes
// RGB332 color type and display palette
//====================

`default_nettype none

package color_pkg;

	typedef enum logic [2:0] {
		UNVISITED,
		CURRENT,
		VISITED,
		TREASURE_7K,
		TREASURE_12K,
		TREASURE_17K
	} cell_state_t;

	// rrr_ggg_bb
	typedef logic [7:0] color_t;

	localparam color_t COLOR_UNVISITED    = 8'b000_111_11;
	localparam color_t COLOR_CURRENT      = 8'b111_111_00;
	localparam color_t COLOR_VISITED      = 8'b111_000_11;
	localparam color_t COLOR_OPEN         = 8'b111_111_11;
	localparam color_t COLOR_WALL         = 8'b000_000_00;

	// treasure markers
	localparam color_t COLOR_TREASURE_7K  = 8'b111_000_00;
	localparam color_t COLOR_TREASURE_12K = 8'b000_111_00;
	localparam color_t COLOR_TREASURE_17K = 8'b000_000_11;

	// outer border once the run is over
	localparam color_t COLOR_FINISHED     = 8'b000_111_00;

endpackage

`default_nettype wire

/* hdl/map_write_if.sv */
//====================
// map write bus, tracker to map store
//====================

`timescale 1ns/1ns
`default_nettype none

interface map_write_if;

	// one cell state write
	logic                   cell_we;
	maze_pkg::cell_x_t      cell_x;
	maze_pkg::cell_y_t      cell_y;
	color_pkg::cell_state_t cell_state;

	// four sides of the cell at cell_x, cell_y
	logic                   wall_we;
	logic                   wall_west;
	logic                   wall_east;
	logic                   wall_south;
	logic                   wall_north;

	// single cycle, ends the run
	logic                   finish;

	modport tracker (
		output cell_we, cell_x, cell_y, cell_state,
		output wall_we, wall_west, wall_east, wall_south, wall_north,
		output finish
	);

	modport store (
		input cell_we, cell_x, cell_y, cell_state,
		input wall_we, wall_west, wall_east, wall_south, wall_north,
		input finish
	);

endinterface

`default_nettype wire

/* hdl/map_read_if.sv */
//====================
// map lookup bus, renderer to map store
//====================

`timescale 1ns/1ns
`default_nettype none

interface map_read_if;

	// cell state lookup
	maze_pkg::cell_x_t      rd_cell_x;
	maze_pkg::cell_y_t      rd_cell_y;
	color_pkg::cell_state_t rd_state;

	// vertical wall, line column 0 to 4 and cell row
	logic [2:0]             vwall_col;
	maze_pkg::cell_y_t      vwall_row;
	logic                   vwall_bit;

	// horizontal wall, line row 0 to 5 and cell column
	logic [2:0]             hwall_row;
	maze_pkg::cell_x_t      hwall_col;
	logic                   hwall_bit;

	logic                   finished;

	modport renderer (
		output rd_cell_x, rd_cell_y, vwall_col, vwall_row, hwall_row, hwall_col,
		input  rd_state, vwall_bit, hwall_bit, finished
	);

	modport store (
		input  rd_cell_x, rd_cell_y, vwall_col, vwall_row, hwall_row, hwall_col,
		output rd_state, vwall_bit, hwall_bit, finished
	);

endinterface

`default_nettype wire

/* hdl/move_tracker.sv */
//====================
// update acceptance with valid/ready
// FSM that sequences visited, cell and wall writes
//====================

`timescale 1ns/1ns
`default_nettype none

module move_tracker (
	input  logic                  CLOCK_25,
	input  logic                  reset,
	input  logic                  update_valid,
	input  maze_pkg::maze_update_t update_data,
	output logic                  update_ready,
	map_write_if.tracker          map_wr
);

	typedef enum logic [2:0] {
		IDLE,
		MARK_PREVIOUS,
		WRITE_CELL,
		FINALIZE,
		DONE
	} state_t;

	state_t                 state_q;
	maze_pkg::maze_update_t upd_q;
	maze_pkg::cell_x_t      prev_x_q;
	maze_pkg::cell_y_t      prev_y_q;
	logic                   has_prev_q;
	logic                   is_done;
	color_pkg::cell_state_t cur_state;

	assign update_ready = (state_q == IDLE);
	assign is_done      = (upd_q.done == maze_pkg::DONE_CODE);

	// treasure code picks the marker for the current cell
	always_comb begin
		case (upd_q.treasure)
			2'd1:    cur_state = color_pkg::TREASURE_7K;
			2'd2:    cur_state = color_pkg::TREASURE_12K;
			2'd3:    cur_state = color_pkg::TREASURE_17K;
			default: cur_state = color_pkg::CURRENT;
		endcase
	end

	//====================
	// state and position registers
	//====================
	always_ff @(posedge CLOCK_25) begin
		if (reset) begin
			state_q    <= IDLE;
			has_prev_q <= 1'b0;
		end else begin
			case (state_q)
				IDLE:          if (update_valid) state_q <= MARK_PREVIOUS;
				MARK_PREVIOUS: state_q <= WRITE_CELL;
				WRITE_CELL: begin
					state_q    <= FINALIZE;
					has_prev_q <= 1'b1;
				end
				FINALIZE:      state_q <= is_done ? DONE : IDLE;
				default:       state_q <= DONE;
			endcase
		end
	end

	always_ff @(posedge CLOCK_25) begin
		if (update_valid && update_ready) upd_q <= update_data;
		if (state_q == WRITE_CELL) begin
			prev_x_q <= upd_q.x;
			prev_y_q <= upd_q.y;
		end
	end

	//====================
	// write strobes
	//====================
	always_comb begin
		map_wr.cell_we    = 1'b0;
		map_wr.cell_x     = upd_q.x;
		map_wr.cell_y     = upd_q.y;
		map_wr.cell_state = cur_state;
		map_wr.wall_we    = 1'b0;
		map_wr.wall_west  = upd_q.wall_west;
		map_wr.wall_east  = upd_q.wall_east;
		map_wr.wall_south = upd_q.wall_south;
		map_wr.wall_north = upd_q.wall_north;
		map_wr.finish     = 1'b0;
		case (state_q)
			MARK_PREVIOUS: begin
				// nothing to mark on the first update
				map_wr.cell_we    = has_prev_q;
				map_wr.cell_x     = prev_x_q;
				map_wr.cell_y     = prev_y_q;
				map_wr.cell_state = color_pkg::VISITED;
			end
			WRITE_CELL: begin
				map_wr.cell_we = 1'b1;
				map_wr.wall_we = 1'b1;
			end
			FINALIZE: map_wr.finish = is_done;
			default: ;
		endcase
	end

	// robot only reports rows inside the maze
	a_row_in_range: assert property (@(posedge CLOCK_25) disable iff (reset)
		(update_valid && update_ready) |-> (update_data.y < maze_pkg::CELL_ROWS));

endmodule

`default_nettype wire

/* hdl/maze_map_store.sv */
//====================
// cell states, wall bits and finished flag
// reset picture, writes and combinational lookups
//====================

`timescale 1ns/1ns
`default_nettype none

module maze_map_store (
	input  logic        CLOCK_25,
	input  logic        reset,
	map_write_if.store  map_wr,
	map_read_if.store   map_rd
);

	color_pkg::cell_state_t cell_state_q [maze_pkg::CELL_ROWS][maze_pkg::CELL_COLS];
	logic vwall_q [maze_pkg::CELL_COLS+1][maze_pkg::CELL_ROWS];
	logic hwall_q [maze_pkg::CELL_ROWS+1][maze_pkg::CELL_COLS];
	logic finished_q;

	//====================
	// reset picture and writes
	//====================
	always_ff @(posedge CLOCK_25) begin
		if (reset) begin
			finished_q <= 1'b0;
			for (int r = 0; r < maze_pkg::CELL_ROWS; r++) begin
				for (int c = 0; c < maze_pkg::CELL_COLS; c++) begin
					cell_state_q[r][c] <= color_pkg::UNVISITED;
				end
			end
			// outer lines closed, inner lines open
			for (int c = 0; c <= maze_pkg::CELL_COLS; c++) begin
				for (int r = 0; r < maze_pkg::CELL_ROWS; r++) begin
					vwall_q[c][r] <= (c == 0) || (c == maze_pkg::CELL_COLS);
				end
			end
			for (int r = 0; r <= maze_pkg::CELL_ROWS; r++) begin
				for (int c = 0; c < maze_pkg::CELL_COLS; c++) begin
					hwall_q[r][c] <= (r == 0) || (r == maze_pkg::CELL_ROWS);
				end
			end
		end else begin
			if (map_wr.cell_we) cell_state_q[map_wr.cell_y][map_wr.cell_x] <= map_wr.cell_state;
			if (map_wr.wall_we) begin
				vwall_q[map_wr.cell_x][map_wr.cell_y]              <= map_wr.wall_west;
				vwall_q[{1'b0, map_wr.cell_x} + 3'd1][map_wr.cell_y] <= map_wr.wall_east;
				hwall_q[map_wr.cell_y][map_wr.cell_x]              <= map_wr.wall_north;
				hwall_q[map_wr.cell_y + 3'd1][map_wr.cell_x]       <= map_wr.wall_south;
			end
			if (map_wr.finish) finished_q <= 1'b1;
		end
	end

	//====================
	// lookups
	//====================
	// indices past the map edge read as empty
	assign map_rd.rd_state = (map_rd.rd_cell_y < maze_pkg::CELL_ROWS) ?
		cell_state_q[map_rd.rd_cell_y][map_rd.rd_cell_x] : color_pkg::UNVISITED;
	assign map_rd.vwall_bit =
		(map_rd.vwall_col <= maze_pkg::CELL_COLS && map_rd.vwall_row < maze_pkg::CELL_ROWS) ?
		vwall_q[map_rd.vwall_col][map_rd.vwall_row] : 1'b0;
	assign map_rd.hwall_bit = (map_rd.hwall_row <= maze_pkg::CELL_ROWS) ?
		hwall_q[map_rd.hwall_row][map_rd.hwall_col] : 1'b0;
	assign map_rd.finished = finished_q;

	// the tracker stops writing once the run is over
	a_frozen_after_finish: assert property (@(posedge CLOCK_25) disable iff (reset)
		finished_q |-> !(map_wr.cell_we || map_wr.wall_we));

endmodule

`default_nettype wire

/* hdl/tile_renderer.sv */
//====================
// pixel coordinate to RGB332 color
// stage 1 tile split, stage 2 map lookup and palette
//====================

`timescale 1ns/1ns
`default_nettype none

module tile_renderer (
	input  logic                    CLOCK_25,
	input  logic                    reset,
	input  maze_pkg::pixel_coord_t  pixel_x,
	input  maze_pkg::pixel_coord_t  pixel_y,
	output color_pkg::color_t       pixel_color,
	map_read_if.renderer            map_rd
);

	// where a tile sits inside its cell
	typedef enum logic [1:0] {
		CLS_CELL,
		CLS_HWALL,
		CLS_VWALL,
		CLS_CORNER
	} tile_class_t;

	logic [5:0]        tile_col_d, tile_row_d;
	logic [5:0]        s1_tile_col, s1_tile_row;
	logic [2:0]        s1_cell_col, s1_cell_row;
	tile_class_t       s1_class;
	logic              s1_out_of_map;
	logic              s1_valid;
	logic              on_border;
	color_pkg::color_t color_d;

	assign tile_col_d = 6'(pixel_x / maze_pkg::TILE_PIXELS);
	assign tile_row_d = 6'(pixel_y / maze_pkg::TILE_PIXELS);

	//====================
	// stage 1
	//====================
	always_ff @(posedge CLOCK_25) begin
		s1_tile_col   <= tile_col_d;
		s1_tile_row   <= tile_row_d;
		s1_cell_col   <= 3'(tile_col_d / maze_pkg::TILES_PER_CELL);
		s1_cell_row   <= 3'(tile_row_d / maze_pkg::TILES_PER_CELL);
		s1_class      <= tile_class_t'({tile_col_d % maze_pkg::TILES_PER_CELL == 0,
			tile_row_d % maze_pkg::TILES_PER_CELL == 0});
		s1_out_of_map <= (pixel_x >= maze_pkg::MAP_PIXEL_W) ||
			(pixel_y >= maze_pkg::MAP_PIXEL_H);
	end

	// lookups use the line or cell index that matches the class
	assign map_rd.rd_cell_x = s1_cell_col[1:0];
	assign map_rd.rd_cell_y = s1_cell_row;
	assign map_rd.vwall_col = s1_cell_col;
	assign map_rd.vwall_row = s1_cell_row;
	assign map_rd.hwall_row = s1_cell_row;
	assign map_rd.hwall_col = s1_cell_col[1:0];

	assign on_border = (s1_tile_col == 0) || (s1_tile_col == maze_pkg::MAP_TILE_COLS - 1) ||
		(s1_tile_row == 0) || (s1_tile_row == maze_pkg::MAP_TILE_ROWS - 1);

	//====================
	// stage 2
	//====================
	always_comb begin
		if (s1_out_of_map) color_d = color_pkg::COLOR_OPEN;
		else if (map_rd.finished && on_border) color_d = color_pkg::COLOR_FINISHED;
		else begin
			case (s1_class)
				CLS_CORNER: color_d = on_border ? color_pkg::COLOR_WALL : color_pkg::COLOR_OPEN;
				CLS_VWALL:  color_d = map_rd.vwall_bit ? color_pkg::COLOR_WALL : color_pkg::COLOR_OPEN;
				CLS_HWALL:  color_d = map_rd.hwall_bit ? color_pkg::COLOR_WALL : color_pkg::COLOR_OPEN;
				default: begin
					case (map_rd.rd_state)
						color_pkg::CURRENT:      color_d = color_pkg::COLOR_CURRENT;
						color_pkg::VISITED:      color_d = color_pkg::COLOR_VISITED;
						color_pkg::TREASURE_7K:  color_d = color_pkg::COLOR_TREASURE_7K;
						color_pkg::TREASURE_12K: color_d = color_pkg::COLOR_TREASURE_12K;
						color_pkg::TREASURE_17K: color_d = color_pkg::COLOR_TREASURE_17K;
						default:                 color_d = color_pkg::COLOR_UNVISITED;
					endcase
				end
			endcase
		end
	end

	// output stays black until stage 1 holds a real coordinate
	always_ff @(posedge CLOCK_25) begin
		if (reset) begin
			s1_valid    <= 1'b0;
			pixel_color <= '0;
		end else begin
			s1_valid <= 1'b1;
			if (s1_valid) pixel_color <= color_d;
		end
	end

endmodule

`default_nettype wire

/* hdl/maze_display.sv */
//====================
// maze display top level
// update tracker, map store and tile renderer
//====================

`timescale 1ns/1ns
`default_nettype none

module maze_display (
	input  logic        CLOCK_25,
	input  logic        reset,
	input  logic        update_valid,
	input  logic [15:0] update_data,
	output logic        update_ready,
	input  logic [9:0]  pixel_x,
	input  logic [9:0]  pixel_y,
	output logic [7:0]  pixel_color,
	output logic        maze_finished
);

	map_write_if map_wr_bus ();
	map_read_if  map_rd_bus ();

	move_tracker u_move_tracker (
		.CLOCK_25     (CLOCK_25),
		.reset        (reset),
		.update_valid (update_valid),
		.update_data  (update_data),
		.update_ready (update_ready),
		.map_wr       (map_wr_bus)
	);

	maze_map_store u_maze_map_store (
		.CLOCK_25 (CLOCK_25),
		.reset    (reset),
		.map_wr   (map_wr_bus),
		.map_rd   (map_rd_bus)
	);

	tile_renderer u_tile_renderer (
		.CLOCK_25    (CLOCK_25),
		.reset       (reset),
		.pixel_x     (pixel_x),
		.pixel_y     (pixel_y),
		.pixel_color (pixel_color),
		.map_rd      (map_rd_bus)
	);

	// attach point for the end-of-run tone
	assign maze_finished = map_rd_bus.finished;

endmodule

`default_nettype wire

/* test/maze_display_tb.sv */
//====================
// maze display testbench
// model map, directed tests, color and flag compares
// cycle counter timeout
//====================

`timescale 1ns/1ns
`default_nettype none

module maze_display_tb;

	// 30 random updates plus the directed ones
	localparam int N_UPDATES   = 42;
	// directed probes plus a 200 pixel random stream
	localparam int N_PROBES    = 280;
	localparam int CYCLE_LIMIT = N_UPDATES * 8 + N_PROBES * 4 + 200;

	logic                   CLOCK_25;
	logic                   reset;
	logic                   update_valid;
	maze_pkg::maze_update_t update_data;
	logic                   update_ready;
	maze_pkg::pixel_coord_t pixel_x;
	maze_pkg::pixel_coord_t pixel_y;
	color_pkg::color_t      pixel_color;
	logic                   maze_finished;

	int          cycle_count = 0;
	int          checks      = 0;
	int          errors      = 0;
	int          tests_run   = 0;
	int unsigned rng_state   = 87736;

	// model map
	color_pkg::cell_state_t m_state [maze_pkg::CELL_ROWS][maze_pkg::CELL_COLS];
	logic m_vwall [maze_pkg::CELL_COLS+1][maze_pkg::CELL_ROWS];
	logic m_hwall [maze_pkg::CELL_ROWS+1][maze_pkg::CELL_COLS];
	logic m_finished;
	logic m_has_prev;
	int   m_prev_x;
	int   m_prev_y;

	maze_display u_maze_display (
		.CLOCK_25      (CLOCK_25),
		.reset         (reset),
		.update_valid  (update_valid),
		.update_data   (update_data),
		.update_ready  (update_ready),
		.pixel_x       (pixel_x),
		.pixel_y       (pixel_y),
		.pixel_color   (pixel_color),
		.maze_finished (maze_finished)
	);

	always #5 CLOCK_25 = ~CLOCK_25;

	always @(posedge CLOCK_25) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("run stopped after %0d cycles, the DUT stopped responding", cycle_count);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	//====================
	// helpers
	//====================
	function automatic int unsigned lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state >> 8;
	endfunction

	function automatic maze_pkg::maze_update_t make_update(input int x, input int y,
		input int tr, input bit w, input bit e, input bit s, input bit n, input int done);
		maze_pkg::maze_update_t u;
		u            = '0;
		u.done       = 3'(done);
		u.y          = 3'(y);
		u.x          = 2'(x);
		u.treasure   = 2'(tr);
		u.wall_west  = w;
		u.wall_east  = e;
		u.wall_south = s;
		u.wall_north = n;
		return u;
	endfunction

	// random cell and walls with the outer sides kept closed
	function automatic maze_pkg::maze_update_t random_update();
		maze_pkg::maze_update_t u;
		int x;
		int y;
		x = lcg_next() % maze_pkg::CELL_COLS;
		y = lcg_next() % maze_pkg::CELL_ROWS;
		u = make_update(x, y, lcg_next() % 4, lcg_next() % 2, lcg_next() % 2,
			lcg_next() % 2, lcg_next() % 2, lcg_next() % maze_pkg::DONE_CODE);
		u.visited     = lcg_next() % 2;
		u.unreachable = lcg_next() % 2;
		if (x == 0) u.wall_west = 1'b1;
		if (x == maze_pkg::CELL_COLS - 1) u.wall_east = 1'b1;
		if (y == 0) u.wall_north = 1'b1;
		if (y == maze_pkg::CELL_ROWS - 1) u.wall_south = 1'b1;
		return u;
	endfunction

	// pixel in the middle of a cell
	function automatic int cell_px(input int i);
		return (i * maze_pkg::TILES_PER_CELL + 4) * maze_pkg::TILE_PIXELS + 5;
	endfunction

	// pixel on a grid line
	function automatic int line_px(input int i);
		return i * maze_pkg::TILES_PER_CELL * maze_pkg::TILE_PIXELS + 5;
	endfunction

	task automatic init_model();
		for (int r = 0; r < maze_pkg::CELL_ROWS; r++)
			for (int c = 0; c < maze_pkg::CELL_COLS; c++)
				m_state[r][c] = color_pkg::UNVISITED;
		for (int c = 0; c <= maze_pkg::CELL_COLS; c++)
			for (int r = 0; r < maze_pkg::CELL_ROWS; r++)
				m_vwall[c][r] = (c == 0) || (c == maze_pkg::CELL_COLS);
		for (int r = 0; r <= maze_pkg::CELL_ROWS; r++)
			for (int c = 0; c < maze_pkg::CELL_COLS; c++)
				m_hwall[r][c] = (r == 0) || (r == maze_pkg::CELL_ROWS);
		m_finished = 1'b0;
		m_has_prev = 1'b0;
	endtask

	task automatic model_apply(input maze_pkg::maze_update_t d);
		int x;
		int y;
		x = d.x;
		y = d.y;
		if (!m_finished) begin
			if (m_has_prev) m_state[m_prev_y][m_prev_x] = color_pkg::VISITED;
			case (d.treasure)
				2'd1:    m_state[y][x] = color_pkg::TREASURE_7K;
				2'd2:    m_state[y][x] = color_pkg::TREASURE_12K;
				2'd3:    m_state[y][x] = color_pkg::TREASURE_17K;
				default: m_state[y][x] = color_pkg::CURRENT;
			endcase
			m_vwall[x][y]     = d.wall_west;
			m_vwall[x + 1][y] = d.wall_east;
			m_hwall[y][x]     = d.wall_north;
			m_hwall[y + 1][x] = d.wall_south;
			m_prev_x   = x;
			m_prev_y   = y;
			m_has_prev = 1'b1;
			if (d.done == maze_pkg::DONE_CODE) m_finished = 1'b1;
		end
	endtask

	// expected color of a pixel from the model map
	function automatic color_pkg::color_t model_color(input int x, input int y);
		int  tc;
		int  tr;
		bit  border;
		tc     = x / maze_pkg::TILE_PIXELS;
		tr     = y / maze_pkg::TILE_PIXELS;
		border = (tc == 0) || (tc == maze_pkg::MAP_TILE_COLS - 1) ||
			(tr == 0) || (tr == maze_pkg::MAP_TILE_ROWS - 1);
		if (x >= maze_pkg::MAP_PIXEL_W || y >= maze_pkg::MAP_PIXEL_H)
			return color_pkg::COLOR_OPEN;
		if (m_finished && border) return color_pkg::COLOR_FINISHED;
		if (tc % 9 == 0 && tr % 9 == 0)
			return border ? color_pkg::COLOR_WALL : color_pkg::COLOR_OPEN;
		if (tc % 9 == 0)
			return m_vwall[tc / 9][tr / 9] ? color_pkg::COLOR_WALL : color_pkg::COLOR_OPEN;
		if (tr % 9 == 0)
			return m_hwall[tr / 9][tc / 9] ? color_pkg::COLOR_WALL : color_pkg::COLOR_OPEN;
		case (m_state[tr / 9][tc / 9])
			color_pkg::CURRENT:      return color_pkg::COLOR_CURRENT;
			color_pkg::VISITED:      return color_pkg::COLOR_VISITED;
			color_pkg::TREASURE_7K:  return color_pkg::COLOR_TREASURE_7K;
			color_pkg::TREASURE_12K: return color_pkg::COLOR_TREASURE_12K;
			color_pkg::TREASURE_17K: return color_pkg::COLOR_TREASURE_17K;
			default:                 return color_pkg::COLOR_UNVISITED;
		endcase
	endfunction

	//====================
	// compares
	//====================
	task automatic check_color(input string name, input color_pkg::color_t got,
		input color_pkg::color_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR at %0t ns: %s is %02h, expected %02h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR at %0t ns: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	//====================
	// bus drivers
	//====================
	// one coordinate in flight with the color read after the second edge
	task automatic probe_pixel(input int x, input int y, input color_pkg::color_t exp);
		@(posedge CLOCK_25);
		pixel_x <= 10'(x);
		pixel_y <= 10'(y);
		repeat (2) @(posedge CLOCK_25);
		@(negedge CLOCK_25);
		check_color($sformatf("pixel_color at (%0d,%0d)", x, y), pixel_color, exp);
	endtask

	task automatic probe_model(input int x, input int y);
		probe_pixel(x, y, model_color(x, y));
	endtask

	task automatic check_cell(input int cx, input int cy);
		probe_model(cell_px(cx), cell_px(cy));
		probe_model(line_px(cx), cell_px(cy));
		probe_model(line_px(cx + 1), cell_px(cy));
		probe_model(cell_px(cx), line_px(cy));
		probe_model(cell_px(cx), line_px(cy + 1));
	endtask

	// returns right after the edge that takes the update
	task automatic send_update(input maze_pkg::maze_update_t d);
		@(posedge CLOCK_25);
		update_valid <= 1'b1;
		update_data  <= d;
		do @(negedge CLOCK_25); while (!update_ready);
		@(posedge CLOCK_25);
		update_valid <= 1'b0;
		model_apply(d);
	endtask

	task automatic wait_ready();
		int low_cycles;
		low_cycles = 0;
		@(negedge CLOCK_25);
		while (!update_ready) begin
			low_cycles++;
			@(negedge CLOCK_25);
		end
		checks++;
		if (low_cycles != 3) begin
			errors++;
			$display("ERROR at %0t ns: update_ready low for %0d cycles, expected 3",
				$time, low_cycles);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) $display("%s: ok", name);
		else $display("%s: %0d errors", name, errors - errors_before);
	endtask

	//====================
	// tests
	//====================
	task automatic test_reset_picture();
		int e0;
		e0 = errors;
		// pipeline still empty one edge after reset
		repeat (2) @(negedge CLOCK_25);
		check_color("pixel_color", pixel_color, 8'h00);
		probe_pixel(5, 5, color_pkg::COLOR_WALL);
		probe_pixel(5, 200, color_pkg::COLOR_WALL);
		probe_pixel(200, 455, color_pkg::COLOR_WALL);
		probe_pixel(369, 459, color_pkg::COLOR_WALL);
		probe_pixel(95, 95, color_pkg::COLOR_OPEN);
		probe_pixel(95, 50, color_pkg::COLOR_OPEN);
		probe_pixel(50, 275, color_pkg::COLOR_OPEN);
		probe_pixel(50, 50, color_pkg::COLOR_UNVISITED);
		probe_pixel(300, 420, color_pkg::COLOR_UNVISITED);
		probe_pixel(400, 50, color_pkg::COLOR_OPEN);
		probe_pixel(50, 470, color_pkg::COLOR_OPEN);
		check_flag("maze_finished", maze_finished, 1'b0);
		check_flag("update_ready", update_ready, 1'b1);
		report_test("test 1 reset picture", e0);
	endtask

	task automatic test_single_update();
		int e0;
		e0 = errors;
		send_update(make_update(1, 2, 0, 1, 0, 1, 0, 0));
		wait_ready();
		probe_pixel(135, 225, color_pkg::COLOR_CURRENT);
		probe_pixel(95, 225, color_pkg::COLOR_WALL);
		probe_pixel(185, 225, color_pkg::COLOR_OPEN);
		probe_pixel(135, 185, color_pkg::COLOR_OPEN);
		probe_pixel(135, 275, color_pkg::COLOR_WALL);
		report_test("test 2 single update", e0);
	endtask

	task automatic test_treasures();
		int e0;
		e0 = errors;
		send_update(make_update(3, 0, 1, 0, 1, 1, 1, 0));
		wait_ready();
		probe_pixel(cell_px(3), cell_px(0), color_pkg::COLOR_TREASURE_7K);
		probe_pixel(cell_px(1), cell_px(2), color_pkg::COLOR_VISITED);
		send_update(make_update(0, 4, 2, 1, 0, 1, 0, 0));
		wait_ready();
		probe_pixel(cell_px(0), cell_px(4), color_pkg::COLOR_TREASURE_12K);
		probe_pixel(cell_px(3), cell_px(0), color_pkg::COLOR_VISITED);
		send_update(make_update(2, 3, 3, 0, 1, 0, 0, 0));
		wait_ready();
		probe_pixel(cell_px(2), cell_px(3), color_pkg::COLOR_TREASURE_17K);
		probe_pixel(cell_px(0), cell_px(4), color_pkg::COLOR_VISITED);
		// same cell again without treasure
		send_update(make_update(2, 3, 0, 0, 1, 0, 0, 0));
		wait_ready();
		probe_pixel(cell_px(2), cell_px(3), color_pkg::COLOR_CURRENT);
		check_cell(2, 3);
		report_test("test 3 treasures and visited", e0);
	endtask

	// valid stays high across the busy cycles
	task automatic test_back_pressure();
		maze_pkg::maze_update_t ups [4];
		int e0;
		int i;
		int last_accept;
		e0          = errors;
		i           = 0;
		last_accept = 0;
		for (int k = 0; k < 4; k++)
			ups[k] = make_update(k, 1, 0, k == 0, k == 3, k % 2, 0, 0);
		@(posedge CLOCK_25);
		update_valid <= 1'b1;
		update_data  <= ups[0];
		while (i < 4) begin
			@(negedge CLOCK_25);
			if (update_ready) begin
				checks++;
				if (i > 0 && cycle_count - last_accept != 4) begin
					errors++;
					$display("ERROR at %0t ns: update %0d taken %0d cycles after the last, expected 4",
						$time, i, cycle_count - last_accept);
				end
				last_accept = cycle_count;
				model_apply(ups[i]);
				i++;
				@(posedge CLOCK_25);
				if (i < 4) update_data <= ups[i];
				else update_valid <= 1'b0;
			end
		end
		wait_ready();
		for (int k = 0; k < 4; k++) check_cell(k, 1);
		report_test("test 4 back-pressure", e0);
	endtask

	// pixels stream in one per cycle with two in flight
	task automatic test_random();
		color_pkg::color_t exp_q [$];
		string             name_q [$];
		int                e0;
		int                x;
		int                y;
		e0 = errors;
		for (int k = 0; k < 30; k++) begin
			send_update(random_update());
			wait_ready();
		end
		for (int k = 0; k < 202; k++) begin
			@(posedge CLOCK_25);
			if (k < 200) begin
				x = lcg_next() % 400;
				y = lcg_next() % 480;
				pixel_x <= 10'(x);
				pixel_y <= 10'(y);
				exp_q.push_back(model_color(x, y));
				name_q.push_back($sformatf("pixel_color at (%0d,%0d)", x, y));
			end
			@(negedge CLOCK_25);
			if (k >= 2) check_color(name_q.pop_front(), pixel_color, exp_q.pop_front());
		end
		report_test("test 5 random updates and pixels", e0);
	endtask

	task automatic test_finish();
		int e0;
		e0 = errors;
		send_update(make_update(1, 0, 0, 0, 0, 0, 1, maze_pkg::DONE_CODE));
		repeat (4) @(negedge CLOCK_25);
		check_flag("maze_finished", maze_finished, 1'b1);
		// a further update must not be taken
		@(posedge CLOCK_25);
		update_valid <= 1'b1;
		update_data  <= make_update(2, 2, 1, 0, 0, 0, 0, 0);
		repeat (10) begin
			@(negedge CLOCK_25);
			check_flag("update_ready", update_ready, 1'b0);
		end
		@(posedge CLOCK_25);
		update_valid <= 1'b0;
		probe_model(5, 5);
		probe_model(200, 5);
		probe_model(5, 300);
		probe_model(365, 200);
		probe_model(200, 455);
		check_cell(1, 0);
		check_cell(2, 2);
		report_test("test 6 finished state", e0);
	endtask

	initial begin
		CLOCK_25     = 1'b0;
		reset        = 1'b1;
		update_valid = 1'b0;
		update_data  = '0;
		// coordinate held through reset lies inside a cell
		pixel_x      = 10'd50;
		pixel_y      = 10'd50;
		init_model();
		repeat (2) @(posedge CLOCK_25);
		reset <= 1'b0;
		test_reset_picture();
		test_single_update();
		test_treasures();
		test_back_pressure();
		test_random();
		test_finish();
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* maze_display.f */
hdl/maze_pkg.sv
hdl/color_pkg.sv
hdl/map_write_if.sv
hdl/map_read_if.sv
hdl/move_tracker.sv
hdl/maze_map_store.sv
hdl/tile_renderer.sv
hdl/maze_display.sv
test/maze_display_tb.sv
